//--- filelist.f
+incdir+testbench
src/memPkg.sv
src/memPortIf.sv
src/byteRam.sv
src/instFetchPort.sv
src/dataAccessPort.sv
src/memArbiter.sv
src/memSubsystem.sv
testbench/memSubsystemTb.sv

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module memSubsystemTb -Mdir obj_dir

status=0
./obj_dir/VmemSubsystemTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

//--- testbench/memTbTasks.svh
`ifndef memTbTasksSvh
`define memTbTasksSvh

// count and report a mismatch between two values
task automatic checkValue(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
        errors++;
        $display("ERR %s expected %08h actual %08h", name, expected, actual);
    end
endtask

// zero-extended little-endian read of the shadow memory
function automatic logic [31:0] shadowRead(input logic [31:0] addr, input accessLen len);
    logic [31:0] val;
    int          i;
    val = '0;
    for (i = 0; i < int'(len); i++) begin
        val[8*i +: 8] = shadow[ramAddrWidth'(addr + 32'(i))];
    end
    return val;
endfunction

// present entry k to the DUT at the next rising edge
task automatic raiseRequest(input int k);
    @(posedge clk);
    if (ops[k] != opFetch) begin
        dataEn    <= 1'b1;
        dataWrite <= ops[k] == opStore;
        dataLen   <= lens[k];
        dataAddr  <= addrs[k];
        dataWdata <= wdatas[k];
    end
    if (ops[k] == opFetch || ops[k] == opBoth) begin
        fetchEn   <= 1'b1;
        fetchAddr <= fAddrs[k];
    end
endtask

// freeze mid-load for a fixed stretch with no done allowed
task automatic holdFrozen(input int k);
    // wait for the grant so a read beat is pending when the freeze hits
    @(negedge clk);
    while (busy != busyData) begin
        @(negedge clk);
    end
    @(posedge clk);
    ioBufferFull <= holds[k] == holdIo;
    ready        <= holds[k] != holdReady;
    repeat (freezeLen) begin
        @(negedge clk);
        checkValue({names[k], " done while frozen"}, 32'd0,
                   {30'd0, fetchDone, dataDone});
    end
    @(posedge clk);
    ioBufferFull <= 1'b0;
    ready        <= 1'b1;
endtask

`endif

//--- testbench/memSubsystemTb.sv
module memSubsystemTb import memPkg::*; ();

    localparam int resetCycles = 4;
    localparam int freezeLen   = 10;
    localparam int idleCycles  = 5;

    typedef enum int {opStore, opLoad, opFetch, opBoth} tbOp;
    typedef enum int {holdNone, holdIo, holdReady} holdKind;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 ready;
    logic                 ioBufferFull;
    logic                 fetchEn;
    logic [addrWidth-1:0] fetchAddr;
    logic                 fetchDone;
    logic [wordWidth-1:0] fetchInst;
    logic                 dataEn;
    logic                 dataWrite;
    accessLen             dataLen;
    logic [addrWidth-1:0] dataAddr;
    logic [wordWidth-1:0] dataWdata;
    logic                 dataDone;
    logic [wordWidth-1:0] dataRdata;
    busyCode              busy;

    // stimulus table, one entry per index
    string       names[$];
    tbOp         ops[$];
    accessLen    lens[$];
    logic [31:0] addrs[$];
    logic [31:0] fAddrs[$];
    holdKind     holds[$];
    logic [31:0] wdatas[$];
    logic [31:0] expDatas[$];
    logic [31:0] expFetches[$];

    logic [7:0] shadow [1 << ramAddrWidth];
    int         seed = 32'h305d5112;
    int         errors = 0;
    int         cycles = 0;
    int         cycleLimit;
    int         freezeCycles = 0;

    `include "memTbTasks.svh"

    memSubsystem dut (
        .clk          (clk),
        .rst          (rst),
        .ready        (ready),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataWrite    (dataWrite),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .busy         (busy)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, a done pulse never arrived", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // stores update the shadow, loads and fetches take their expected value from it
    task automatic addEntry(input string name, input tbOp op, input accessLen len,
                            input logic [31:0] addr, input logic [31:0] fAddr,
                            input holdKind hold);
        logic [31:0] wdata;
        int          i;
        wdata = '0;
        if (op == opStore) begin
            wdata = $random(seed);
            for (i = 0; i < int'(len); i++) begin
                shadow[ramAddrWidth'(addr + 32'(i))] = wdata[8*i +: 8];
            end
        end
        names.push_back(name);
        ops.push_back(op);
        lens.push_back(len);
        addrs.push_back(addr);
        fAddrs.push_back(fAddr);
        holds.push_back(hold);
        wdatas.push_back(wdata);
        expDatas.push_back((op == opLoad || op == opBoth) ? shadowRead(addr, len) : '0);
        expFetches.push_back((op == opFetch || op == opBoth) ? shadowRead(fAddr, lenWord) : '0);
        if (hold != holdNone) begin
            freezeCycles += freezeLen;
        end
    endtask

    task automatic applyEntry(input int k);
        bit          wantData;
        bit          wantFetch;
        bit          gotData;
        bit          gotFetch;
        bit          sawBusyData;
        bit          sawBusyFetch;
        bit          fetchEarly;
        logic [31:0] dataVal;
        logic [31:0] fetchVal;
        wantData     = ops[k] != opFetch;
        wantFetch    = ops[k] == opFetch || ops[k] == opBoth;
        gotData      = 1'b0;
        gotFetch     = 1'b0;
        sawBusyData  = 1'b0;
        sawBusyFetch = 1'b0;
        fetchEarly   = 1'b0;
        dataVal      = '0;
        fetchVal     = '0;
        raiseRequest(k);
        if (holds[k] != holdNone) begin
            holdFrozen(k);
        end
        while ((wantData && !gotData) || (wantFetch && !gotFetch)) begin
            @(negedge clk);
            if (busy == busyData) begin
                sawBusyData = 1'b1;
            end
            // data must own the RAM first when both ask together
            if (busy == busyFetch || fetchDone) begin
                sawBusyFetch = 1'b1;
                fetchEarly   = fetchEarly || (wantData && !gotData);
            end
            if (dataDone) begin
                gotData = 1'b1;
                dataVal = dataRdata;
            end
            if (fetchDone) begin
                gotFetch = 1'b1;
                fetchVal = fetchInst;
            end
            @(posedge clk);
            if (gotData) begin
                dataEn <= 1'b0;
            end
            if (gotFetch) begin
                fetchEn <= 1'b0;
            end
        end
        if (ops[k] == opLoad || ops[k] == opBoth) begin
            checkValue(names[k], expDatas[k], dataVal);
        end
        if (wantFetch) begin
            checkValue({names[k], " inst"}, expFetches[k], fetchVal);
            checkValue({names[k], " busyFetch seen"}, 32'd1, 32'(sawBusyFetch));
        end
        if (ops[k] == opBoth) begin
            checkValue({names[k], " busyData seen"}, 32'd1, 32'(sawBusyData));
            checkValue({names[k], " fetch ahead of data"}, 32'd0, 32'(fetchEarly));
        end
    endtask

    initial begin
        int k;
        rst          = 1'b1;
        ready        = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataWrite    = 1'b0;
        dataLen      = lenWord;
        dataAddr     = '0;
        dataWdata    = '0;

        addEntry("stw0", opStore, lenWord, 32'h100, 32'h0, holdNone);
        addEntry("stw1", opStore, lenWord, 32'h104, 32'h0, holdNone);
        addEntry("ldw0", opLoad, lenWord, 32'h100, 32'h0, holdNone);
        addEntry("ldh0", opLoad, lenHalf, 32'h100, 32'h0, holdNone);
        addEntry("ldh2", opLoad, lenHalf, 32'h102, 32'h0, holdNone);
        addEntry("ldb1", opLoad, lenByte, 32'h101, 32'h0, holdNone);
        addEntry("ldb3", opLoad, lenByte, 32'h103, 32'h0, holdNone);
        addEntry("ldh3", opLoad, lenHalf, 32'h103, 32'h0, holdNone);
        addEntry("stb2", opStore, lenByte, 32'h102, 32'h0, holdNone);
        addEntry("sth5", opStore, lenHalf, 32'h105, 32'h0, holdNone);
        addEntry("ldMerge0", opLoad, lenWord, 32'h100, 32'h0, holdNone);
        addEntry("ldMerge1", opLoad, lenWord, 32'h104, 32'h0, holdNone);
        addEntry("ldw2", opLoad, lenWord, 32'h102, 32'h0, holdNone);
        addEntry("fetch0", opFetch, lenWord, 32'h100, 32'h100, holdNone);
        addEntry("fetch1", opFetch, lenWord, 32'h104, 32'h104, holdNone);
        // word straddling the top of the 1 KiB space
        addEntry("stWrap", opStore, lenWord, 32'h3fe, 32'h0, holdNone);
        addEntry("ldWrap", opLoad, lenWord, 32'h3fe, 32'h0, holdNone);
        addEntry("both", opBoth, lenHalf, 32'h106, 32'h100, holdNone);
        addEntry("frzIo", opLoad, lenWord, 32'h104, 32'h0, holdIo);
        addEntry("frzReady", opLoad, lenByte, 32'h102, 32'h0, holdReady);
        addEntry("ldAfter", opLoad, lenWord, 32'h100, 32'h0, holdNone);

        cycleLimit = names.size() * 20 + freezeCycles + resetCycles;

        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;

        // quiet outputs with nothing requested
        repeat (idleCycles) begin
            @(negedge clk);
            checkValue("idle fetchDone", 32'd0, 32'(fetchDone));
            checkValue("idle dataDone", 32'd0, 32'(dataDone));
            checkValue("idle busy", 32'(busyNone), 32'(busy));
        end

        for (k = 0; k < names.size(); k++) begin
            applyEntry(k);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- src/memSubsystem.sv
module memSubsystem import memPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ready,
    input  logic                 ioBufferFull,
    input  logic                 fetchEn,
    input  logic [addrWidth-1:0] fetchAddr,
    output logic                 fetchDone,
    output logic [wordWidth-1:0] fetchInst,
    input  logic                 dataEn,
    input  logic                 dataWrite,
    input  accessLen             dataLen,
    input  logic [addrWidth-1:0] dataAddr,
    input  logic [wordWidth-1:0] dataWdata,
    output logic                 dataDone,
    output logic [wordWidth-1:0] dataRdata,
    output busyCode              busy
);

    logic [ramAddrWidth-1:0] ramAddr;
    logic                    ramWriteEn;
    logic [byteWidth-1:0]    ramWrData;
    logic [byteWidth-1:0]    ramRdData;

    memPortIf fetchBus ();
    memPortIf dataBus ();

    instFetchPort fetchPort (
        .clk       (clk),
        .rst       (rst),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .bus       (fetchBus)
    );

    dataAccessPort dataPort (
        .clk       (clk),
        .rst       (rst),
        .dataEn    (dataEn),
        .dataWrite (dataWrite),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .bus       (dataBus)
    );

    memArbiter arbiter (
        .clk          (clk),
        .rst          (rst),
        .ready        (ready),
        .ioBufferFull (ioBufferFull),
        .fetchBus     (fetchBus),
        .dataBus      (dataBus),
        .ramAddr      (ramAddr),
        .ramWriteEn   (ramWriteEn),
        .ramWrData    (ramWrData),
        .ramRdData    (ramRdData),
        .busy         (busy)
    );

    byteRam ram (
        .clk     (clk),
        .addr    (ramAddr),
        .writeEn (ramWriteEn),
        .wrData  (ramWrData),
        .rdData  (ramRdData)
    );

endmodule

//--- src/memArbiter.sv
module memArbiter import memPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ready,
    input  logic                    ioBufferFull,
    memPortIf.arbiter               fetchBus,
    memPortIf.arbiter               dataBus,
    output logic [ramAddrWidth-1:0] ramAddr,
    output logic                    ramWriteEn,
    output logic [byteWidth-1:0]    ramWrData,
    input  logic [byteWidth-1:0]    ramRdData,
    output busyCode                 busy
);

    busyCode  owner;
    beatIndex cnt;
    logic     issueDone;
    logic     pendValid;
    beatIndex pendBeat;
    logic     pendLast;

    logic                 frozen;
    logic                 grantFetch;
    logic                 ownWrite;
    accessLen             ownLen;
    logic [addrWidth-1:0] ownBase;
    logic [byteWidth-1:0] ownWrByte;
    logic                 issuing;
    logic                 lastBeat;
    logic                 writeBeat;
    logic                 readBeat;
    logic                 rdValidNow;
    logic                 doneNow;
    beatIndex             addrBeat;
    logic [addrWidth-1:0] byteAddr;

    assign frozen     = !ready || ioBufferFull;
    assign grantFetch = owner == busyFetch;

    // fields of the current owner
    assign ownWrite  = grantFetch ? fetchBus.isWrite  : dataBus.isWrite;
    assign ownLen    = grantFetch ? fetchBus.len      : dataBus.len;
    assign ownBase   = grantFetch ? fetchBus.baseAddr : dataBus.baseAddr;
    assign ownWrByte = grantFetch ? fetchBus.wrByte   : dataBus.wrByte;

    assign issuing    = owner != busyNone && !issueDone;
    assign lastBeat   = 3'({1'b0, cnt}) + 3'd1 == ownLen;
    assign writeBeat  = issuing && ownWrite;
    assign readBeat   = issuing && !ownWrite;
    assign rdValidNow = pendValid && !frozen;
    assign doneNow    = !frozen && ((writeBeat && lastBeat) || (rdValidNow && pendLast));

    // keep the pending read address on the RAM during a freeze
    assign addrBeat = (frozen && pendValid) ? pendBeat : cnt;
    assign byteAddr = ownBase + addrWidth'(addrBeat);

    assign ramAddr    = byteAddr[ramAddrWidth-1:0];
    assign ramWriteEn = writeBeat && !frozen;
    assign ramWrData  = ownWrByte;
    assign busy       = owner;

    assign fetchBus.beat    = cnt;
    assign fetchBus.rdValid = rdValidNow && grantFetch;
    assign fetchBus.rdBeat  = pendBeat;
    assign fetchBus.rdByte  = ramRdData;
    assign fetchBus.done    = doneNow && grantFetch;

    assign dataBus.beat    = cnt;
    assign dataBus.rdValid = rdValidNow && owner == busyData;
    assign dataBus.rdBeat  = pendBeat;
    assign dataBus.rdByte  = ramRdData;
    assign dataBus.done    = doneNow && owner == busyData;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner     <= busyNone;
            cnt       <= '0;
            issueDone <= 1'b0;
            pendValid <= 1'b0;
        end else if (!frozen) begin
            pendValid <= readBeat;
            pendBeat  <= cnt;
            pendLast  <= lastBeat;
            if (owner == busyNone) begin
                cnt       <= '0;
                issueDone <= 1'b0;
                // data wins only on an idle RAM
                if (dataBus.req) begin
                    owner <= busyData;
                end else if (fetchBus.req) begin
                    owner <= busyFetch;
                end
            end else begin
                if (issuing) begin
                    if (lastBeat) begin
                        cnt       <= '0;
                        issueDone <= 1'b1;
                    end else begin
                        cnt <= cnt + 2'd1;
                    end
                end
                if (doneNow) begin
                    owner     <= busyNone;
                    cnt       <= '0;
                    issueDone <= 1'b0;
                end
            end
        end
    end

    grantHeld: assert property (@(posedge clk) disable iff (rst)
        (owner != busyNone && !doneNow) |=> $stable(owner));

    oneOwner: assert property (@(posedge clk) disable iff (rst)
        !(fetchBus.rdValid && dataBus.rdValid) && !(fetchBus.done && dataBus.done));

endmodule

//--- src/dataAccessPort.sv
module dataAccessPort import memPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dataEn,
    input  logic                 dataWrite,
    input  accessLen             dataLen,
    input  logic [addrWidth-1:0] dataAddr,
    input  logic [wordWidth-1:0] dataWdata,
    output logic                 dataDone,
    output logic [wordWidth-1:0] dataRdata,
    memPortIf.requester          bus
);

    logic                 active;
    logic                 start;
    logic                 writeReg;
    accessLen             lenReg;
    logic [addrWidth-1:0] addrReg;
    logic [wordWidth-1:0] wdataReg;
    logic [wordWidth-1:0] asmWord;
    logic [wordWidth-1:0] merged;

    assign start = !active && dataEn && !dataDone;

    assign bus.req      = active;
    assign bus.isWrite  = writeReg;
    assign bus.len      = lenReg;
    assign bus.baseAddr = addrReg;
    // store byte for whichever beat the arbiter is on
    assign bus.wrByte   = wdataReg[bus.beat * byteWidth +: byteWidth];

    always_comb begin
        merged = asmWord;
        if (bus.rdValid) begin
            merged[bus.rdBeat * byteWidth +: byteWidth] = bus.rdByte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            dataDone <= 1'b0;
        end else begin
            dataDone <= bus.done;
            if (bus.done) begin
                active <= 1'b0;
            end else if (start) begin
                active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            writeReg <= dataWrite;
            lenReg   <= dataLen;
            addrReg  <= dataAddr;
            wdataReg <= dataWdata;
        end
        if (bus.done) begin
            // zero extension; stores come back as zero
            dataRdata <= merged & lenMask(lenReg);
            asmWord   <= '0;
        end else if (bus.rdValid) begin
            asmWord <= merged;
        end
    end

    // latched length must be a legal size for the whole request
    lenLegal: assert property (@(posedge clk) disable iff (rst)
        bus.req |-> bus.len inside {lenByte, lenHalf, lenWord});

endmodule

//--- src/instFetchPort.sv
module instFetchPort import memPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetchEn,
    input  logic [addrWidth-1:0] fetchAddr,
    output logic                 fetchDone,
    output logic [wordWidth-1:0] fetchInst,
    memPortIf.requester          bus
);

    logic                 active;
    logic                 start;
    logic [addrWidth-1:0] addrReg;
    logic [wordWidth-1:0] asmWord;
    logic [wordWidth-1:0] merged;

    // fetchDone still high means the pipeline has not seen the last result yet
    assign start = !active && fetchEn && !fetchDone;

    assign bus.req      = active;
    assign bus.isWrite  = 1'b0;
    assign bus.len      = lenWord;
    assign bus.baseAddr = addrReg;
    assign bus.wrByte   = '0;

    always_comb begin
        merged = asmWord;
        if (bus.rdValid) begin
            merged[bus.rdBeat * byteWidth +: byteWidth] = bus.rdByte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            fetchDone <= bus.done;
            if (bus.done) begin
                active <= 1'b0;
            end else if (start) begin
                active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addrReg <= fetchAddr;
        end
        if (bus.done) begin
            fetchInst <= merged;
            asmWord   <= '0;
        end else if (bus.rdValid) begin
            asmWord <= merged;
        end
    end

    // read bytes only come back for a fetch in flight
    rdOnlyWhileReq: assert property (@(posedge clk) disable iff (rst)
        bus.rdValid |-> bus.req);

endmodule

//--- src/byteRam.sv
module byteRam import memPkg::*; (
    input  logic                    clk,
    input  logic [ramAddrWidth-1:0] addr,
    input  logic                    writeEn,
    input  logic [byteWidth-1:0]    wrData,
    output logic [byteWidth-1:0]    rdData
);

    logic [byteWidth-1:0] mem [ramDepth];

    // read returns the old byte when the same address is written
    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[addr] <= wrData;
        end
        rdData <= mem[addr];
    end

endmodule

//--- src/memPortIf.sv
interface memPortIf
    import memPkg::*;
();
    // requester side
    logic                 req;
    logic                 isWrite;
    accessLen             len;
    logic [addrWidth-1:0] baseAddr;
    logic [byteWidth-1:0] wrByte;

    // arbiter side
    beatIndex             beat;
    logic                 rdValid;
    beatIndex             rdBeat;
    logic [byteWidth-1:0] rdByte;
    logic                 done;

    modport requester (
        output req, isWrite, len, baseAddr, wrByte,
        input  beat, rdValid, rdBeat, rdByte, done
    );

    modport arbiter (
        input  req, isWrite, len, baseAddr, wrByte,
        output beat, rdValid, rdBeat, rdByte, done
    );

endinterface

//--- src/memPkg.sv
package memPkg;

    localparam int addrWidth    = 32;
    localparam int wordWidth    = 32;
    localparam int byteWidth    = 8;

    // only the low bits reach the RAM, so addresses wrap at 1 KiB
    localparam int ramAddrWidth = 10;
    localparam int ramDepth     = 1 << ramAddrWidth;

    // transfer length in bytes
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen;

    // who currently owns the RAM
    typedef enum logic [1:0] {
        busyNone  = 2'd0,
        busyData  = 2'd1,
        busyFetch = 2'd2
    } busyCode;

    // byte lane within a word
    typedef logic [1:0] beatIndex;

    // bytes kept by a zero-extended load
    function automatic logic [wordWidth-1:0] lenMask(input accessLen len);
        logic [wordWidth-1:0] mask;
        case (len)
            lenByte: mask = {{(wordWidth - byteWidth){1'b0}}, {byteWidth{1'b1}}};
            lenHalf: mask = {{(wordWidth - 2 * byteWidth){1'b0}}, {(2 * byteWidth){1'b1}}};
            default: mask = '1;
        endcase
        return mask;
    endfunction

endpackage
